// File: verilog.f
+incdir+rtl
rtl/aluPkg.sv
rtl/aluCmdIf.sv
rtl/opIngress.sv
rtl/opFifo.sv
rtl/aluCore.sv
rtl/seqDivider.sv
rtl/aluExec.sv
rtl/aluTop.sv
tb/aluTb.sv

// File: tb/aluTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module aluTb;
	import aluPkg::*;

	localparam int ClkNs = 100;
	localparam int WatchdogNs = 300 * 60 * ClkNs + 5 * ClkNs; // commands x cycles + reset

	logic clk;
	logic arstN;
	logic opReq;
	logic opAck;
	aluWord value1;
	aluWord value2;
	aluOp select;
	logic resReq;
	logic resAck;
	aluWide result;

	aluWide expQ [$]; // expected results in issue order
	logic sinkOn;
	logic [31:0] rng;
	int errors;
	int checks;
	int tests;

	aluTop dut_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic aluWide aluModel(input aluWord a, input aluWord b, input logic [3:0] code);
		logic [4:0] s;
		aluWord w;
		s = b[4:0]; // only the low five bits count
		w = '0;
		case (code)
			4'd1: w = a + b;
			4'd2: w = a - b;
			4'd3: w = a & b;
			4'd4: w = a | b;
			4'd5: w = -a;
			4'd6: w = ~a;
			4'd7: w = a >> s;
			4'd8: w = a << s;
			4'd9: w = (a >> s) | (a << (6'd32 - s));
			4'd10: w = (a << s) | (a >> (6'd32 - s));
			4'd11: return (b == 0) ? {a, 32'hffff_ffff} : {a % b, a / b};
			4'd12: return {32'b0, a} * {32'b0, b};
			4'd13: w = (a >> s) | ({32{a[31]}} & ~(32'hffff_ffff >> s)); // sign fill
			default: w = '0;
		endcase
		return {32'b0, w};
	endfunction

	task automatic checkResult(input aluWide exp, input aluWide act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] result expected %h got %h", exp, act);
		end
	endtask

	task automatic checkAccepted(input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("[ERROR] accepted count expected %h got %h", exp, act);
		end
	endtask

	task automatic checkLevel(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic issueCmd(input aluWord a, input aluWord b, input logic [3:0] code);
		@(posedge clk);
		#5;
		value1 = a;
		value2 = b;
		select = aluOp'(code);
		opReq = 1'b1;
		expQ.push_back(aluModel(a, b, code));
	endtask

	task automatic awaitAck(input int maxCycles, output bit acked);
		acked = 1'b0;
		for (int i = 0; i < maxCycles && !acked; i++) begin
			@(posedge clk);
			acked = opAck;
		end
	endtask

	task automatic dropReq();
		#5;
		opReq = 1'b0;
		@(posedge clk);
		while (opAck) @(posedge clk);
	endtask

	task automatic runCmd(input aluWord a, input aluWord b, input logic [3:0] code);
		bit acked;
		issueCmd(a, b, code);
		awaitAck(200, acked);
		if (!acked) begin
			errors++;
			$display("command with select %0d was never acknowledged", code);
		end
		dropReq();
	endtask

	task automatic drain(input int maxCycles);
		int n;
		n = 0;
		while ((expQ.size() != 0 || resReq || resAck) && n < maxCycles) begin
			@(posedge clk);
			n++;
		end
		if (expQ.size() != 0) begin
			errors++;
			$display("%0d results still missing after %0d cycles", expQ.size(), maxCycles);
		end
	endtask

	task automatic endTest(input string name);
		tests++;
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	initial begin
		clk = 1'b0;
		forever #(ClkNs / 2) clk = ~clk;
	end

	// sink acks each result unless held off
	initial begin
		resAck = 1'b0;
		forever begin
			@(posedge clk);
			#5;
			if (resReq && sinkOn)
				resAck = 1'b1;
			else if (!resReq)
				resAck = 1'b0;
		end
	end

	initial begin : compare
		logic wasReq;
		wasReq = 1'b0;
		forever begin
			@(posedge clk);
			if (resReq && !wasReq) begin // new result
				if (expQ.size() == 0) begin
					errors++;
					$display("result arrived with no command outstanding");
				end else begin
					checkResult(expQ.pop_front(), result);
				end
			end
			wasReq = resReq;
		end
	end

	initial begin
		#(WatchdogNs);
		$display("watchdog expired, the DUT stopped responding");
		$display("TB FAILED");
		$finish;
	end

	initial begin : main
		bit ok;
		int accepted;
		aluWord a;
		aluWord b;
		arstN = 1'b0;
		opReq = 1'b0;
		value1 = '0;
		value2 = '0;
		select = opAdd;
		sinkOn = 1'b0;
		rng = 32'h1c87;
		repeat (5) @(posedge clk);
		#5;
		arstN = 1'b1;
		checkLevel("opAck", 1'b0, opAck);
		checkLevel("resReq", 1'b0, resReq);
		endTest("reset");

		sinkOn = 1'b1;
		for (int c = 0; c < 16; c++)
			runCmd(32'hf0f0_1234, 32'h0000_0027, 4'(c)); // unused codes too
		drain(300);
		endTest("all codes");

		runCmd(32'h1234_5678, 32'h0, 4'd11); // divide by zero
		runCmd(32'hffff_ffff, 32'h1, 4'd11);
		for (int c = 7; c <= 10; c++)
			runCmd(32'h8765_4321, 32'h0000_0124, 4'(c)); // amount above 31
		runCmd(32'h8000_0010, 32'h4, 4'd13);
		runCmd(32'hffff_ffff, 32'hffff_ffff, 4'd12);
		drain(300);
		endTest("edge cases");

		for (int i = 0; i < 250; i++) begin
			rng = xorshift(rng);
			a = rng;
			rng = xorshift(rng);
			b = rng;
			rng = xorshift(rng);
			runCmd(a, b, rng[3:0]);
		end
		drain(2000);
		endTest("random");

		sinkOn = 1'b0;
		accepted = 0;
		for (int i = 0; i < `ALU_FIFO_DEPTH + 2; i++) begin
			rng = xorshift(rng);
			issueCmd(rng, ~rng, 4'(2 * i + 1)); // includes a divide
			awaitAck(100, ok);
			if (ok) begin
				accepted++;
				dropReq();
			end
		end
		checkAccepted(`ALU_FIFO_DEPTH + 1, accepted);
		sinkOn = 1'b1;
		awaitAck(200, ok);
		if (!ok) begin
			errors++;
			$display("held command was not acknowledged after the sink resumed");
		end
		dropReq();
		drain(500);
		endTest("backpressure");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/aluTop.sv
`timescale 1ns/1ns
`default_nettype none

module aluTop (
	input  logic clk,
	input  logic arstN,
	input  logic opReq,
	output logic opAck,
	input  aluPkg::aluWord value1,
	input  aluPkg::aluWord value2,
	input  aluPkg::aluOp select,
	output logic resReq,
	input  logic resAck,
	output aluPkg::aluWide result
);

	aluCmdIf pushIf ();
	aluCmdIf popIf ();

	opIngress ingress_i (
		.clk    (clk),
		.arstN  (arstN),
		.opReq  (opReq),
		.opAck  (opAck),
		.value1 (value1),
		.value2 (value2),
		.select (select),
		.cmd    (pushIf.send)
	);

	opFifo fifo_i (
		.clk    (clk),
		.arstN  (arstN),
		.inCmd  (pushIf.recv),
		.outCmd (popIf.send)
	);

	aluExec exec_i (
		.clk    (clk),
		.arstN  (arstN),
		.cmd    (popIf.recv),
		.resReq (resReq),
		.resAck (resAck),
		.result (result)
	);

endmodule

`default_nettype wire

// File: rtl/aluExec.sv
`timescale 1ns/1ns
`default_nettype none

module aluExec (
	input  logic clk,
	input  logic arstN,
	aluCmdIf.recv cmd,
	output logic resReq,
	input  logic resAck,
	output aluPkg::aluWide result
);
	import aluPkg::*;

	execState state;
	aluWord v1Reg;
	aluWord v2Reg;
	aluOp selReg;
	aluWide coreOut;
	aluWide resReg;
	aluWord quotient;
	aluWord remainder;
	logic divStart;
	logic divDone;

	aluCore core_i (
		.value1 (v1Reg),
		.value2 (v2Reg),
		.select (selReg),
		.result (coreOut)
	);

	seqDivider div_i (
		.clk       (clk),
		.arstN     (arstN),
		.start     (divStart),
		.dividend  (v1Reg),
		.divisor   (v2Reg),
		.done      (divDone),
		.quotient  (quotient),
		.remainder (remainder)
	);

	assign cmd.ready = state == execIdle; // one command in flight
	assign divStart = state == execCalc && selReg == opDiv;
	assign resReq = state == execPresent;
	assign result = resReg;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= execIdle;
		end else begin
			case (state)
				execIdle: if (cmd.valid) state <= execCalc;
				execCalc: state <= (selReg == opDiv) ? execDivWait : execPresent;
				execDivWait: if (divDone) state <= execPresent;
				execPresent: if (resAck) state <= execWaitDrop;
				execWaitDrop: if (!resAck) state <= execIdle;
				default: state <= execIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.valid && cmd.ready) begin
			v1Reg <= cmd.value1;
			v2Reg <= cmd.value2;
			selReg <= cmd.select;
		end
		if (state == execCalc && selReg != opDiv)
			resReg <= coreOut;
		else if (state == execDivWait && divDone)
			resReg <= {remainder, quotient}; // quotient in low word
	end

endmodule

`default_nettype wire

// File: rtl/seqDivider.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module seqDivider (
	input  logic clk,
	input  logic arstN,
	input  logic start,
	input  aluPkg::aluWord dividend,
	input  aluPkg::aluWord divisor,
	output logic done,
	output aluPkg::aluWord quotient,
	output aluPkg::aluWord remainder
);
	import aluPkg::*;

	localparam int Steps = `ALU_WIDTH;
	localparam int CntW = $clog2(Steps);

	logic [CntW-1:0] count;
	logic busy;
	aluWord remReg;
	aluWord quoReg;
	aluWord dvsReg;
	aluWord remIn;
	aluWord quoIn;
	aluWord dvsIn;
	logic [`ALU_WIDTH:0] shifted;
	logic [`ALU_WIDTH:0] diff;
	logic fits;

	// first bit resolves in the start cycle
	always_comb begin
		remIn = start ? '0 : remReg;
		quoIn = start ? dividend : quoReg;
		dvsIn = start ? divisor : dvsReg;
		shifted = {remIn, quoIn[`ALU_WIDTH-1]};
		diff = shifted - {1'b0, dvsIn};
		fits = shifted >= {1'b0, dvsIn}; // always true for a zero divisor
	end

	always_ff @(posedge clk) begin
		if (start || busy) begin
			remReg <= fits ? diff[`ALU_WIDTH-1:0] : shifted[`ALU_WIDTH-1:0];
			quoReg <= {quoIn[`ALU_WIDTH-2:0], fits};
			dvsReg <= dvsIn;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= CntW'(Steps - 1);
			end else if (busy) begin
				count <= count - 1'b1;
				if (count == 1) begin
					busy <= 1'b0;
					done <= 1'b1; // last bit this cycle
				end
			end
		end
	end

	assign quotient = quoReg;
	assign remainder = remReg;

endmodule

`default_nettype wire

// File: rtl/aluCore.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module aluCore (
	input  aluPkg::aluWord value1,
	input  aluPkg::aluWord value2,
	input  aluPkg::aluOp select,
	output aluPkg::aluWide result
);
	import aluPkg::*;

	aluShamt shamt;
	aluWord word;
	aluWide product;
	aluWide dblRight;
	aluWide dblLeft;

	assign shamt = value2[$bits(aluShamt)-1:0]; // upper bits ignored
	assign product = aluWide'(value1) * aluWide'(value2);

	// rotates from a doubled word
	assign dblRight = {value1, value1} >> shamt;
	assign dblLeft = {value1, value1} << shamt;

	always_comb begin
		word = '0;
		case (select)
			opAdd: word = value1 + value2;
			opSub: word = value1 - value2;
			opAnd: word = value1 & value2;
			opOr: word = value1 | value2;
			opNeg: word = ~value1 + 1'b1;
			opNot: word = ~value1;
			opShr: word = value1 >> shamt;
			opShl: word = value1 << shamt;
			opRor: word = dblRight[`ALU_WIDTH-1:0];
			opRol: word = dblLeft[2*`ALU_WIDTH-1:`ALU_WIDTH];
			opSar: word = aluWord'($signed(value1) >>> shamt);
			default: word = '0; // divide handled outside, unused codes
		endcase
	end

	assign result = (select == opMul) ? product : {{`ALU_WIDTH{1'b0}}, word};

endmodule

`default_nettype wire

// File: rtl/opFifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "alu_defines.svh"

module opFifo (
	input  logic clk,
	input  logic arstN,
	aluCmdIf.recv inCmd,
	aluCmdIf.send outCmd
);
	import aluPkg::*;

	localparam int Depth = `ALU_FIFO_DEPTH;

	aluWord v1Mem [Depth];
	aluWord v2Mem [Depth];
	aluOp selMem [Depth];
	logic [`ALU_PTR_WIDTH-1:0] wrPtr;
	logic [`ALU_PTR_WIDTH-1:0] rdPtr;
	logic [`ALU_PTR_WIDTH:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [`ALU_PTR_WIDTH-1:0] nextPtr(input logic [`ALU_PTR_WIDTH-1:0] ptr);
		return (ptr == Depth - 1) ? '0 : ptr + 1'b1;
	endfunction

	assign inCmd.ready = count != Depth; // not full
	assign outCmd.valid = count != '0;
	assign doPush = inCmd.valid && inCmd.ready;
	assign doPop = outCmd.valid && outCmd.ready;

	assign outCmd.value1 = v1Mem[rdPtr];
	assign outCmd.value2 = v2Mem[rdPtr];
	assign outCmd.select = selMem[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush) begin
			v1Mem[wrPtr] <= inCmd.value1;
			v2Mem[wrPtr] <= inCmd.value2;
			selMem[wrPtr] <= inCmd.select;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= nextPtr(wrPtr);
			if (doPop) rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or push with pop
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/opIngress.sv
`timescale 1ns/1ns
`default_nettype none

module opIngress (
	input  logic clk,
	input  logic arstN,
	input  logic opReq,
	output logic opAck,
	input  aluPkg::aluWord value1,
	input  aluPkg::aluWord value2,
	input  aluPkg::aluOp select,
	aluCmdIf.send cmd
);
	import aluPkg::*;

	ingState state;
	aluWord v1Reg;
	aluWord v2Reg;
	aluOp selReg;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= ingIdle;
		end else begin
			case (state)
				ingIdle: if (opReq) state <= ingPush;
				ingPush: if (cmd.ready) state <= ingWaitDrop; // pushed into FIFO
				ingWaitDrop: if (!opReq) state <= ingIdle;
				default: state <= ingIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ingIdle && opReq) begin
			v1Reg <= value1;
			v2Reg <= value2;
			selReg <= select;
		end
	end

	assign cmd.valid = state == ingPush;
	assign cmd.value1 = v1Reg;
	assign cmd.value2 = v2Reg;
	assign cmd.select = selReg;
	assign opAck = state == ingWaitDrop; // held until opReq falls

endmodule

`default_nettype wire

// File: rtl/aluCmdIf.sv
`timescale 1ns/1ns
`default_nettype none

interface aluCmdIf;
	import aluPkg::*;

	aluWord value1;
	aluWord value2;
	aluOp select;
	logic valid;
	logic ready;

	// data held stable while valid waits for ready
	modport send (output value1, value2, select, valid, input ready);
	modport recv (input value1, value2, select, valid, output ready);

endinterface

`default_nettype wire

// File: rtl/aluPkg.sv
`default_nettype none

`include "alu_defines.svh"

package aluPkg;

	typedef logic [`ALU_WIDTH-1:0] aluWord; // operand, quotient or remainder
	typedef logic [2*`ALU_WIDTH-1:0] aluWide; // full result
	typedef logic [$clog2(`ALU_WIDTH)-1:0] aluShamt;

	typedef enum logic [3:0] {
		opAdd = 4'd1,
		opSub,
		opAnd,
		opOr,
		opNeg,
		opNot,
		opShr,
		opShl,
		opRor,
		opRol,
		opDiv,
		opMul,
		opSar = 4'd13
	} aluOp;

	typedef enum logic [1:0] {ingIdle, ingPush, ingWaitDrop} ingState;

	typedef enum logic [2:0] {
		execIdle,
		execCalc,
		execDivWait,
		execPresent,
		execWaitDrop
	} execState;

endpackage

`default_nettype wire

// File: rtl/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand width in bits
`define ALU_WIDTH 32

// command FIFO
`define ALU_FIFO_DEPTH 4
`define ALU_PTR_WIDTH 2 // log2 of depth

`endif
